//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f tb.f --top-module RiscvCoreTb -o simv \
    && ./obj_dir/simv | awk '{ print } /^TEST PASS$/ { found = 1 } END { exit !found }' \
    || exit 1

//--- source/Alu.sv
`timescale 1ns/1ps
`default_nettype none

module Alu import CoreTypes::*; (
    input  AluOp i_Op,
    input  Word  i_A,
    input  Word  i_B,
    output Word  o_Result);

    always_comb begin
        case (i_Op)
            AluOp_ADD:   o_Result = i_A + i_B;
            AluOp_SUB:   o_Result = i_A - i_B;
            AluOp_AND:   o_Result = i_A & i_B;
            AluOp_OR:    o_Result = i_A | i_B;
            AluOp_XOR:   o_Result = i_A ^ i_B;
            AluOp_SLL:   o_Result = i_A << i_B[4:0];       // Only 5 bits of shift
            AluOp_SLT:   o_Result = Word'($signed(i_A) < $signed(i_B));
            AluOp_SLTU:  o_Result = Word'(i_A < i_B);
            AluOp_PASSB: o_Result = i_B;                    // LUI immediate
            default:     o_Result = '0;                     // Unknown op
        endcase
    end

endmodule

`default_nettype wire

//--- source/CoreTypes.sv
`default_nettype none

`include "core_defs.svh"

package CoreTypes;

    typedef logic [`XLEN-1:0] Word;             // Data or instruction word
    typedef logic [4:0]       RegAddr;          // Register index x0..x31

    typedef enum logic [4:0] {
        AluOp_ADD     = 5'd0,
        AluOp_SUB     = 5'd1,
        AluOp_AND     = 5'd2,
        AluOp_OR      = 5'd3,
        AluOp_XOR     = 5'd4,
        AluOp_SLL     = 5'd5,
        AluOp_SLT     = 5'd6,
        AluOp_SLTU    = 5'd7,
        AluOp_PASSB   = 5'd8,                   // Forward operand B (LUI)
        AluOp_Unknown = 5'd31                   // Result is zero
    } AluOp;

    // Write-back select: 2'b00 ALU result, 2'b01 data memory word, 2'b10 PC+4
    // Next-PC select: 2'b00 PC+4, 2'b01 PC+offset, 2'b10 register+offset

    typedef enum logic [1:0] {
        RS_IDLE,                                // Waiting for start
        RS_RUN,                                 // One instruction per cycle
        RS_HALTED                               // Stopped on an illegal word
    } RunState;

endpackage

`default_nettype wire

//--- source/Datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module Datapath import CoreTypes::*; (
    input  logic                clk,
    input  logic                i_rst,
    input  logic                i_Commit,          // Retire current instruction
    input  logic                i_ClearPc,         // Restart at `RESET_PC
    input  AluOp                i_AluControl,
    input  logic                i_OperandASel,     // 1 = PC
    input  logic                i_OperandBSel,     // 1 = immediate
    input  logic                i_RegWrEnable,
    input  logic [1:0]          i_RegWrDataSel,
    input  logic                i_MemWrEnable,
    input  logic [1:0]          i_PCNextSel,
    input  logic                i_ImemWrEnable,    // Program load strobe
    input  logic [`IMEM_AW-1:0] i_ImemAddr,
    input  Word                 i_ImemData,
    input  RegAddr              i_DbgRegAddr,
    output Word                 o_Inst,
    output logic                o_IsEQ,
    output logic                o_IsLT,
    output Word                 o_Pc,
    output Word                 o_DbgRegData);

    Word imem [2**`IMEM_AW];
    Word dmem [2**`DMEM_AW];

    Word pc, pcNext, pcPlus4;
    Word inst, imm;
    Word rs1Data, rs2Data;
    Word opA, opB, aluResult;
    Word memData, wrData, indSum;

    // Instruction fetch, word addressed
    always_ff @(posedge clk) begin
        if (i_ImemWrEnable)
            imem[i_ImemAddr] <= i_ImemData;
    end
    assign inst    = imem[pc[`IMEM_AW+1:2]];
    assign pcPlus4 = pc + 32'd4;

    // Immediate per format, I by default
    always_comb begin
        case (inst[6:0])
            7'b0100011: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};                 // S
            7'b1100011: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};  // B
            7'b0110111,
            7'b0010111: imm = {inst[31:12], 12'b0};                                      // U
            7'b1101111: imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0}; // J
            default:    imm = {{20{inst[31]}}, inst[31:20]};                             // I
        endcase
    end

    RegisterFile RegisterFile_inst (
        .clk        (clk),
        .i_RdAddrA  (inst[19:15]),
        .i_RdAddrB  (inst[24:20]),
        .i_WrAddr   (inst[11:7]),
        .i_DbgAddr  (i_DbgRegAddr),
        .i_WrEnable (i_RegWrEnable && i_Commit),  // No write on halt
        .i_WrData   (wrData),
        .o_RdDataA  (rs1Data),
        .o_RdDataB  (rs2Data),
        .o_DbgData  (o_DbgRegData));

    assign opA = i_OperandASel ? pc  : rs1Data;
    assign opB = i_OperandBSel ? imm : rs2Data;

    Alu Alu_inst (
        .i_Op     (i_AluControl),
        .i_A      (opA),
        .i_B      (opB),
        .o_Result (aluResult));

    // Branch compare, unsigned for BLTU/BGEU
    assign o_IsEQ = rs1Data == rs2Data;
    assign o_IsLT = inst[13] ? (rs1Data < rs2Data) : ($signed(rs1Data) < $signed(rs2Data));

    // Data memory, ALU gives the byte address
    always_ff @(posedge clk) begin
        if (i_MemWrEnable && i_Commit)
            dmem[aluResult[`DMEM_AW+1:2]] <= rs2Data;
    end
    assign memData = dmem[aluResult[`DMEM_AW+1:2]];

    always_comb begin
        case (i_RegWrDataSel)
            2'b01:   wrData = memData;             // LW
            2'b10:   wrData = pcPlus4;             // Link address
            default: wrData = aluResult;
        endcase
    end

    assign indSum = rs1Data + imm;                 // JALR target before alignment

    always_comb begin
        case (i_PCNextSel)
            2'b01:   pcNext = pc + imm;            // Taken branch or JAL
            2'b10:   pcNext = {indSum[`XLEN-1:1], 1'b0};
            default: pcNext = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst || i_ClearPc)
            pc <= `RESET_PC;
        else if (i_Commit)
            pc <= pcNext;                          // Holds on halt
    end

    assign o_Inst = inst;
    assign o_Pc   = pc;

endmodule

`default_nettype wire

//--- source/DatapathController.sv
`timescale 1ns/1ps
`default_nettype none

module DatapathController import CoreTypes::*; (
    input  Word         i_Inst,            // Current instruction
    input  logic        i_IsEQ,            // rs1 == rs2
    input  logic        i_IsLT,            // rs1 < rs2, signedness from funct3
    output logic        o_MemWrEnable,     // Store to data memory
    output logic [1:0]  o_PCNextSel,       // Next PC source
    output AluOp        o_AluControl,
    output logic        o_OperandASel,     // 0 register, 1 PC
    output logic        o_OperandBSel,     // 0 register, 1 immediate
    output logic        o_RegWrEnable,
    output logic [1:0]  o_RegWrDataSel,    // Write-back source
    output logic        o_Illegal);        // Word not supported

    localparam logic [1:0] WR_ALU = 2'b00;
    localparam logic [1:0] WR_MEM = 2'b01;
    localparam logic [1:0] WR_PC4 = 2'b10;

    localparam logic [1:0] PC_PP4 = 2'b00;
    localparam logic [1:0] PC_OFS = 2'b01;
    localparam logic [1:0] PC_IND = 2'b10;

    // Control word fields, msb first
    //   OperandASel, OperandBSel, RegWrDataSel, RegWrEnable, MemWrEnable, PCNextSel, AluControl
    localparam logic [12:0] CW_ADD   = {1'b0, 1'b0, WR_ALU, 1'b1, 1'b0, PC_PP4, AluOp_ADD};
    localparam logic [12:0] CW_SUB   = {1'b0, 1'b0, WR_ALU, 1'b1, 1'b0, PC_PP4, AluOp_SUB};
    localparam logic [12:0] CW_AND   = {1'b0, 1'b0, WR_ALU, 1'b1, 1'b0, PC_PP4, AluOp_AND};
    localparam logic [12:0] CW_OR    = {1'b0, 1'b0, WR_ALU, 1'b1, 1'b0, PC_PP4, AluOp_OR};
    localparam logic [12:0] CW_XOR   = {1'b0, 1'b0, WR_ALU, 1'b1, 1'b0, PC_PP4, AluOp_XOR};
    localparam logic [12:0] CW_SLL   = {1'b0, 1'b0, WR_ALU, 1'b1, 1'b0, PC_PP4, AluOp_SLL};
    localparam logic [12:0] CW_SLT   = {1'b0, 1'b0, WR_ALU, 1'b1, 1'b0, PC_PP4, AluOp_SLT};
    localparam logic [12:0] CW_SLTU  = {1'b0, 1'b0, WR_ALU, 1'b1, 1'b0, PC_PP4, AluOp_SLTU};

    localparam logic [12:0] CW_ADDI  = {1'b0, 1'b1, WR_ALU, 1'b1, 1'b0, PC_PP4, AluOp_ADD};
    localparam logic [12:0] CW_ANDI  = {1'b0, 1'b1, WR_ALU, 1'b1, 1'b0, PC_PP4, AluOp_AND};
    localparam logic [12:0] CW_ORI   = {1'b0, 1'b1, WR_ALU, 1'b1, 1'b0, PC_PP4, AluOp_OR};
    localparam logic [12:0] CW_XORI  = {1'b0, 1'b1, WR_ALU, 1'b1, 1'b0, PC_PP4, AluOp_XOR};
    localparam logic [12:0] CW_SLTI  = {1'b0, 1'b1, WR_ALU, 1'b1, 1'b0, PC_PP4, AluOp_SLT};
    localparam logic [12:0] CW_SLTIU = {1'b0, 1'b1, WR_ALU, 1'b1, 1'b0, PC_PP4, AluOp_SLTU};

    localparam logic [12:0] CW_LUI   = {1'b0, 1'b1, WR_ALU, 1'b1, 1'b0, PC_PP4, AluOp_PASSB};
    localparam logic [12:0] CW_AUIPC = {1'b1, 1'b1, WR_ALU, 1'b1, 1'b0, PC_PP4, AluOp_ADD};

    localparam logic [12:0] CW_BR    = {1'b0, 1'b0, WR_ALU, 1'b0, 1'b0, PC_OFS, AluOp_Unknown};
    localparam logic [12:0] CW_JAL   = {1'b0, 1'b0, WR_PC4, 1'b1, 1'b0, PC_OFS, AluOp_Unknown};
    localparam logic [12:0] CW_JALR  = {1'b0, 1'b0, WR_PC4, 1'b1, 1'b0, PC_IND, AluOp_Unknown};

    localparam logic [12:0] CW_LW    = {1'b0, 1'b1, WR_MEM, 1'b1, 1'b0, PC_PP4, AluOp_ADD};
    localparam logic [12:0] CW_SW    = {1'b0, 1'b1, WR_ALU, 1'b0, 1'b1, PC_PP4, AluOp_ADD};

    logic [12:0] cw;                       // Selected control word
    logic        taken;                    // Branch or jump redirects the PC

    assign o_OperandASel  = cw[12];
    assign o_OperandBSel  = cw[11];
    assign o_RegWrDataSel = cw[10:9];
    assign o_RegWrEnable  = cw[8];
    assign o_MemWrEnable  = cw[7];
    assign o_PCNextSel    = taken ? cw[6:5] : PC_PP4;  // Not taken falls through
    assign o_AluControl   = AluOp'(cw[4:0]);

    // Branch decision from funct3, opcode and compare flags
    always_comb begin
        unique casez ({i_Inst[14:12], i_Inst[6:0], i_IsEQ, i_IsLT})
            12'b000_1100011_1_?: taken = 1'b1;     // BEQ
            12'b001_1100011_0_?: taken = 1'b1;     // BNE
            12'b100_1100011_?_1: taken = 1'b1;     // BLT
            12'b101_1100011_?_0: taken = 1'b1;     // BGE
            12'b110_1100011_?_1: taken = 1'b1;     // BLTU
            12'b111_1100011_?_0: taken = 1'b1;     // BGEU
            12'b???_1101111_?_?: taken = 1'b1;     // JAL
            12'b000_1100111_?_?: taken = 1'b1;     // JALR
            default:             taken = 1'b0;
        endcase
    end

    // Decode funct7, funct3 and opcode
    always_comb begin
        o_Illegal = 1'b0;
        unique casez ({i_Inst[31:25], i_Inst[14:12], i_Inst[6:0]})
            17'b0000000_000_0110011: cw = CW_ADD;
            17'b0100000_000_0110011: cw = CW_SUB;
            17'b0000000_111_0110011: cw = CW_AND;
            17'b0000000_110_0110011: cw = CW_OR;
            17'b0000000_100_0110011: cw = CW_XOR;
            17'b0000000_001_0110011: cw = CW_SLL;
            17'b0000000_010_0110011: cw = CW_SLT;
            17'b0000000_011_0110011: cw = CW_SLTU;
            17'b???????_000_0010011: cw = CW_ADDI;
            17'b???????_111_0010011: cw = CW_ANDI;
            17'b???????_110_0010011: cw = CW_ORI;
            17'b???????_100_0010011: cw = CW_XORI;
            17'b???????_010_0010011: cw = CW_SLTI;
            17'b???????_011_0010011: cw = CW_SLTIU;
            17'b???????_???_0110111: cw = CW_LUI;
            17'b???????_???_0010111: cw = CW_AUIPC;
            17'b???????_00?_1100011: cw = CW_BR;   // BEQ, BNE
            17'b???????_1??_1100011: cw = CW_BR;   // BLT, BGE, BLTU, BGEU
            17'b???????_???_1101111: cw = CW_JAL;
            17'b???????_000_1100111: cw = CW_JALR;
            17'b???????_010_0000011: cw = CW_LW;
            17'b???????_010_0100011: cw = CW_SW;
            default: begin                         // Shifts right, byte/half, system...
                cw        = '0;
                o_Illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/InstretCounter.sv
`timescale 1ns/1ps
`default_nettype none

module InstretCounter import CoreTypes::*; (
    input  logic clk,
    input  logic i_rst,
    input  logic i_Clear,        // Start of a new run
    input  logic i_Increment,    // One instruction retired
    output Word  o_Count);

    always_ff @(posedge clk) begin
        if (i_rst || i_Clear)
            o_Count <= '0;
        else if (i_Increment)
            o_Count <= o_Count + 32'd1;   // Wraps at 32 bits
    end

endmodule

`default_nettype wire

//--- source/RegisterFile.sv
`timescale 1ns/1ps
`default_nettype none

module RegisterFile import CoreTypes::*; (
    input  logic   clk,
    input  RegAddr i_RdAddrA,
    input  RegAddr i_RdAddrB,
    input  RegAddr i_WrAddr,
    input  RegAddr i_DbgAddr,          // Debug port, outside world
    input  logic   i_WrEnable,
    input  Word    i_WrData,
    output Word    o_RdDataA,
    output Word    o_RdDataB,
    output Word    o_DbgData);

    Word regs [32];

    // x0 is hardwired to zero
    function automatic Word readReg(input RegAddr addr);
        return (addr == '0) ? '0 : regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (i_WrEnable && i_WrAddr != '0)
            regs[i_WrAddr] <= i_WrData;  // Writes to x0 dropped
    end

    // Asynchronous reads
    assign o_RdDataA = readReg(i_RdAddrA);
    assign o_RdDataB = readReg(i_RdAddrB);
    assign o_DbgData = readReg(i_DbgAddr);

endmodule

`default_nettype wire

//--- source/RiscvCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module RiscvCore import CoreTypes::*; (
    input  logic                clk,
    input  logic                i_rst,
    input  logic                i_Start,
    input  logic                i_ImemWrEnable,
    input  logic [`IMEM_AW-1:0] i_ImemAddr,
    input  Word                 i_ImemData,
    input  RegAddr              i_DbgRegAddr,
    output logic                o_Running,
    output logic                o_Halted,
    output Word                 o_Pc,
    output Word                 o_Instret,
    output Word                 o_DbgRegData);

    Word        inst;
    logic       isEQ, isLT;
    logic       memWrEnable, regWrEnable;
    logic [1:0] pcNextSel, regWrDataSel;
    AluOp       aluControl;
    logic       operandASel, operandBSel;
    logic       illegal, commit, clearCount;

    DatapathController DatapathController_inst (
        .i_Inst         (inst),
        .i_IsEQ         (isEQ),
        .i_IsLT         (isLT),
        .o_MemWrEnable  (memWrEnable),
        .o_PCNextSel    (pcNextSel),
        .o_AluControl   (aluControl),
        .o_OperandASel  (operandASel),
        .o_OperandBSel  (operandBSel),
        .o_RegWrEnable  (regWrEnable),
        .o_RegWrDataSel (regWrDataSel),
        .o_Illegal      (illegal));

    Datapath Datapath_inst (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_Commit       (commit),
        .i_ClearPc      (clearCount),    // PC restarts with the counter
        .i_AluControl   (aluControl),
        .i_OperandASel  (operandASel),
        .i_OperandBSel  (operandBSel),
        .i_RegWrEnable  (regWrEnable),
        .i_RegWrDataSel (regWrDataSel),
        .i_MemWrEnable  (memWrEnable),
        .i_PCNextSel    (pcNextSel),
        .i_ImemWrEnable (i_ImemWrEnable),
        .i_ImemAddr     (i_ImemAddr),
        .i_ImemData     (i_ImemData),
        .i_DbgRegAddr   (i_DbgRegAddr),
        .o_Inst         (inst),
        .o_IsEQ         (isEQ),
        .o_IsLT         (isLT),
        .o_Pc           (o_Pc),
        .o_DbgRegData   (o_DbgRegData));

    RunControl RunControl_inst (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_Start      (i_Start),
        .i_Illegal    (illegal),
        .o_Commit     (commit),
        .o_ClearCount (clearCount),
        .o_Running    (o_Running),
        .o_Halted     (o_Halted));

    InstretCounter InstretCounter_inst (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_Clear     (clearCount),
        .i_Increment (commit),
        .o_Count     (o_Instret));

endmodule

`default_nettype wire

//--- source/RunControl.sv
`timescale 1ns/1ps
`default_nettype none

module RunControl import CoreTypes::*; (
    input  logic clk,
    input  logic i_rst,
    input  logic i_Start,        // Single-cycle pulse
    input  logic i_Illegal,      // From the decoder
    output logic o_Commit,       // Current instruction retires at next edge
    output logic o_ClearCount,   // Restart PC and counter
    output logic o_Running,
    output logic o_Halted);

    RunState state, stateNext;

    always_comb begin
        stateNext = state;
        case (state)
            RS_RUN: begin
                if (i_Illegal)
                    stateNext = RS_HALTED;
            end
            default: begin               // Idle or halted
                if (i_Start)
                    stateNext = RS_RUN;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst)
            state <= RS_IDLE;
        else
            state <= stateNext;
    end

    assign o_Running    = state == RS_RUN;
    assign o_Halted     = state == RS_HALTED;
    assign o_Commit     = o_Running && !i_Illegal;   // Illegal word writes nothing
    assign o_ClearCount = i_Start && !o_Running;     // Start ignored while running

endmodule

`default_nettype wire

//--- source/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Data and address width
`define XLEN 32

// Word-address widths of the two memories, 256 words each
`define IMEM_AW 8
`define DMEM_AW 8

// PC after reset and after every start
`define RESET_PC 32'h0000_0000

`endif

//--- tb.f
+incdir+source
source/CoreTypes.sv
source/DatapathController.sv
source/Alu.sv
source/RegisterFile.sv
source/Datapath.sv
source/RunControl.sv
source/InstretCounter.sv
source/RiscvCore.sv
verification/ClockGen.sv
verification/RiscvCoreTb.sv

//--- verification/ClockGen.sv
`timescale 1ns/1ps
`default_nettype none

module ClockGen #(
    parameter int PERIOD = 20              // ns
) (
    output logic o_Clk);

    initial begin
        o_Clk = 1'b0;
        forever #(PERIOD / 2) o_Clk = ~o_Clk;   // 50% duty
    end

endmodule

`default_nettype wire

//--- verification/RiscvCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module RiscvCoreTb import CoreTypes::*; ();

    logic                clk;
    logic                i_rst, i_Start, i_ImemWrEnable;
    logic [`IMEM_AW-1:0] i_ImemAddr;
    Word                 i_ImemData;
    RegAddr              i_DbgRegAddr;
    logic                o_Running, o_Halted;
    Word                 o_Pc, o_Instret, o_DbgRegData;

    Word  prog [$];                        // Program being assembled
    Word  modelRegs [32];
    Word  modelMem [256];
    Word  modelPc, expReg, expPc, expInstret;
    int   modelCount, checks, seed;
    int   errors = 0;
    logic chkReg, chkState, expHalted;     // Arm the checks for one edge

    int rF3 [8]  = '{0, 0, 7, 6, 4, 1, 2, 3};      // ADD SUB AND OR XOR SLL SLT SLTU
    int iF3 [8]  = '{0, 7, 6, 4, 2, 3, 0, 0};      // ADDI ANDI ORI XORI SLTI SLTIU
    int bF3 [8]  = '{0, 1, 4, 5, 6, 7, 0, 0};      // BEQ BNE BLT BGE BLTU BGEU
    int pairA [4] = '{1, 2, 2, 4};
    int pairB [4] = '{2, 1, 3, 1};

    ClockGen #(.PERIOD(20)) ClockGen_inst (.o_Clk(clk));

    RiscvCore RiscvCore_inst (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_Start        (i_Start),
        .i_ImemWrEnable (i_ImemWrEnable),
        .i_ImemAddr     (i_ImemAddr),
        .i_ImemData     (i_ImemData),
        .i_DbgRegAddr   (i_DbgRegAddr),
        .o_Running      (o_Running),
        .o_Halted       (o_Halted),
        .o_Pc           (o_Pc),
        .o_Instret      (o_Instret),
        .o_DbgRegData   (o_DbgRegData));

    function automatic void reportMismatch(input string name, input Word got, input Word exp);
        errors++;
        $display("[FAIL] %s: got %h exp %h", name, got, exp);
    endfunction

    // Start while stopped runs from the next cycle
    assert property (@(posedge clk) disable iff (i_rst) i_Start && !o_Running |=> o_Running)
        else reportMismatch("o_Running", {31'b0, $sampled(o_Running)}, 32'h1);
    assert property (@(posedge clk) chkState |-> !o_Running)
        else reportMismatch("o_Running", {31'b0, $sampled(o_Running)}, 32'h0);
    assert property (@(posedge clk) chkState |-> o_Halted == expHalted)
        else reportMismatch("o_Halted", {31'b0, $sampled(o_Halted)}, {31'b0, expHalted});
    assert property (@(posedge clk) chkState |-> o_Pc == expPc)
        else reportMismatch("o_Pc", $sampled(o_Pc), expPc);
    assert property (@(posedge clk) chkState |-> o_Instret == expInstret)
        else reportMismatch("o_Instret", $sampled(o_Instret), expInstret);
    assert property (@(posedge clk) chkReg |-> o_DbgRegData == expReg)
        else reportMismatch($sformatf("o_DbgRegData x%0d", $sampled(i_DbgRegAddr)),
                            $sampled(o_DbgRegData), expReg);

    task automatic tick();
        @(posedge clk);
        #2;                                // Inputs change away from the edge
    endtask

    function automatic Word encR(input int f7, input int rs2, input int rs1, input int f3,
                                 input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic Word encI(input int imm, input int rs1, input int f3, input int rd,
                                 input int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic Word encS(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'd2, imm[4:0], 7'h23};   // SW
    endfunction

    function automatic Word encB(input int off, input int rs2, input int rs1, input int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
    endfunction

    function automatic Word encU(input int imm, input int rd, input int op);
        return {imm[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic Word encJ(input int off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6F};
    endfunction

    // LUI plus ADDI, upper part rounded for the sign of the low 12 bits
    task automatic loadConst(input int rd, input Word v);
        Word hi;
        hi = v + 32'h800;
        prog.push_back(encU(int'(hi[31:12]), rd, 'h37));
        prog.push_back(encI(int'(v[11:0]), rd, 0, rd, 'h13));
    endtask

    // ISA-level interpreter, runs until the first unsupported word
    task automatic runModel();
        Word  pc, nextPc, ins, a, b, res, immI, addr;
        logic illegal, wr, taken;
        int   idx;
        pc         = `RESET_PC;
        modelCount = 0;
        illegal    = 1'b0;
        while (!illegal && modelCount < 1000) begin
            idx    = int'(pc[31:2]);
            ins    = (idx < prog.size()) ? prog[idx] : 32'h0;
            a      = modelRegs[ins[19:15]];
            b      = modelRegs[ins[24:20]];
            immI   = {{20{ins[31]}}, ins[31:20]};
            res    = pc + 32'd4;           // Link value unless replaced
            nextPc = pc + 32'd4;
            wr     = 1'b1;
            taken  = 1'b0;
            case (ins[6:0])
                7'h33: begin
                    case ({ins[31:25], ins[14:12]})
                        10'h000: res = a + b;
                        10'h100: res = a - b;
                        10'h001: res = a << b[4:0];
                        10'h002: res = {31'b0, $signed(a) < $signed(b)};
                        10'h003: res = {31'b0, a < b};
                        10'h004: res = a ^ b;
                        10'h006: res = a | b;
                        10'h007: res = a & b;
                        default: illegal = 1'b1;    // SRL, SRA, unknown funct7
                    endcase
                end
                7'h13: begin
                    case (ins[14:12])
                        3'd0:    res = a + immI;
                        3'd2:    res = {31'b0, $signed(a) < $signed(immI)};
                        3'd3:    res = {31'b0, a < immI};
                        3'd4:    res = a ^ immI;
                        3'd6:    res = a | immI;
                        3'd7:    res = a & immI;
                        default: illegal = 1'b1;    // Shift immediates
                    endcase
                end
                7'h37: res = {ins[31:12], 12'h000};
                7'h17: res = pc + {ins[31:12], 12'h000};
                7'h63: begin
                    wr = 1'b0;
                    case (ins[14:12])
                        3'd0:    taken = a == b;
                        3'd1:    taken = a != b;
                        3'd4:    taken = $signed(a) < $signed(b);
                        3'd5:    taken = $signed(a) >= $signed(b);
                        3'd6:    taken = a < b;
                        3'd7:    taken = a >= b;
                        default: illegal = 1'b1;
                    endcase
                    if (taken)
                        nextPc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
                7'h6F: nextPc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                7'h67: begin
                    illegal = ins[14:12] != 3'd0;
                    nextPc  = (a + immI) & ~32'h1;    // Target low bit cleared
                end
                7'h03: begin
                    addr    = a + immI;
                    illegal = ins[14:12] != 3'd2;     // LW only
                    res     = modelMem[addr[9:2]];
                end
                7'h23: begin
                    addr    = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    wr      = 1'b0;
                    illegal = ins[14:12] != 3'd2;     // SW only
                    if (!illegal)
                        modelMem[addr[9:2]] = b;
                end
                default: illegal = 1'b1;
            endcase
            if (!illegal) begin
                if (wr && ins[11:7] != 5'd0)
                    modelRegs[ins[11:7]] = res;
                pc = nextPc;
                modelCount++;
            end
        end
        modelPc = pc;
    endtask

    task automatic checkState();
        chkState = 1'b1;
        tick();
        chkState = 1'b0;
        checks++;
    endtask

    task automatic checkRegs();
        for (int r = 0; r < 32; r++) begin
            i_DbgRegAddr = r[4:0];
            expReg       = modelRegs[r[4:0]];
            chkReg       = 1'b1;
            tick();
            checks++;
        end
        chkReg = 1'b0;
    endtask

    // Load, start, wait for the halt, then compare with the model
    task automatic runProgram(input string name);
        int t;
        prog.push_back(encR(0, 2, 1, 5, 5));          // SRL x5, x1, x2 stops the core
        foreach (prog[i]) begin
            i_ImemWrEnable = 1'b1;
            i_ImemAddr     = i[`IMEM_AW-1:0];
            i_ImemData     = prog[i];
            tick();
        end
        i_ImemWrEnable = 1'b0;
        runModel();
        i_Start = 1'b1;
        tick();
        i_Start = 1'b0;
        for (t = 0; t < 2000 && !o_Halted; t++)
            tick();
        if (!o_Halted) begin
            $display("Timeout: program %s did not halt within 2000 cycles", name);
            errors++;
        end else begin
            expPc      = modelPc;
            expInstret = Word'(modelCount);
            expHalted  = 1'b1;
            checkState();
            checkRegs();
        end
        prog.delete();
    endtask

    initial begin
        int kind, rd, rs1, rs2, imm;
        seed           = 22;
        checks         = 0;
        i_rst          = 1'b1;
        i_Start        = 1'b0;
        i_ImemWrEnable = 1'b0;
        i_ImemAddr     = '0;
        i_ImemData     = '0;
        i_DbgRegAddr   = '0;
        chkReg         = 1'b0;
        chkState       = 1'b0;
        expReg         = '0;
        expPc          = `RESET_PC;
        expInstret     = '0;
        expHalted      = 1'b0;
        modelRegs      = '{default: '0};
        modelMem       = '{default: '0};
        repeat (10) tick();
        i_rst = 1'b0;
        checkState();                                  // Idle state after reset

        // Random ALU sequence over fully initialized registers
        for (int r = 1; r < 32; r++)
            loadConst(r, $random(seed));
        for (int n = 0; n < 40; n++) begin
            kind = $unsigned($random(seed)) % 16;
            rd   = $unsigned($random(seed)) % 32;      // x0 too
            rs1  = $unsigned($random(seed)) % 32;
            rs2  = $unsigned($random(seed)) % 32;
            imm  = $random(seed);
            if (kind < 8)
                prog.push_back(encR(kind == 1 ? 32 : 0, rs2, rs1, rF3[kind[2:0]], rd));
            else if (kind < 14)
                prog.push_back(encI(imm, rs1, iF3[kind[2:0]], rd, 'h13));
            else
                prog.push_back(encU(imm, rd, kind == 14 ? 'h37 : 'h17));
        end
        runProgram("alu");

        // Every branch kind on signed, unsigned and equal operand pairs
        loadConst(1, 32'hFFFF_FFFB);                   // -5, low signed, high unsigned
        loadConst(2, 32'd3);
        loadConst(3, 32'd3);
        loadConst(4, $random(seed));
        for (int k = 0; k < 6; k++)
            prog.push_back(encI(0, 0, 0, 10 + k, 'h13));
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 4; p++) begin
                prog.push_back(encB(8, pairB[p[1:0]], pairA[p[1:0]], bF3[k[2:0]]));
                prog.push_back(encI(1 << p, 10 + k, 0, 10 + k, 'h13));   // Fall-through mark
            end
        end
        runProgram("branch");

        // JAL and JALR with link registers and an odd JALR offset
        prog.push_back(encI(0, 0, 0, 21, 'h13));
        prog.push_back(encI(0, 0, 0, 22, 'h13));
        prog.push_back(encJ(12, 1));                   // JAL x1 over two marks
        prog.push_back(encI(1, 21, 0, 21, 'h13));
        prog.push_back(encI(2, 21, 0, 21, 'h13));
        prog.push_back(encU(0, 6, 'h17));              // x6 = own address
        prog.push_back(encI(13, 6, 0, 7, 'h67));       // JALR x7, lands at x6+12
        prog.push_back(encI(4, 22, 0, 22, 'h13));
        prog.push_back(encJ(8, 0));                    // No link
        prog.push_back(encI(8, 22, 0, 22, 'h13));
        runProgram("jump");

        // Stores then loads through the same and a different base
        loadConst(2, $random(seed));
        loadConst(3, $random(seed));
        prog.push_back(encI('h40, 0, 0, 1, 'h13));     // Base 0x40
        prog.push_back(encS(0, 2, 1));
        prog.push_back(encS(4, 3, 1));
        prog.push_back(encS(-4, 3, 1));
        prog.push_back(encI(0, 1, 2, 4, 'h03));
        prog.push_back(encI(4, 1, 2, 8, 'h03));
        prog.push_back(encI(8, 1, 0, 9, 'h13));
        prog.push_back(encI(-12, 9, 2, 10, 'h03));     // Word at 0x3C
        prog.push_back(encI(-8, 9, 2, 11, 'h03));      // Word at 0x40
        runProgram("memory");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire
